/* hdl/bridge_cfg_pkg.sv */
// Numeric configuration of the NoC to AXI-Stream bridge
// Widths, credit count, credit-only threshold and queue depths
`default_nettype none

package bridge_cfg_pkg;

  // Flit payload width on the NoC side
  localparam int FlitWidth = 32;

  // Receive queue depth, also the credits per channel after reset
  localparam int NumCredits = 8;

  // Credit count width, must hold NumCredits
  localparam int CreditWidth = 4;

  // Owed credits that trigger a credit-only packet
  localparam int ForceSendThresh = NumCredits - 4;

  // Depth of the registered AXIS output stage
  localparam int OutDepth = 2;

  // tdata is the data header on top of the flit
  localparam int TdataWidth = FlitWidth + 1;

  // tuser holds data-valid, credit header and credit count
  localparam int TuserWidth = 2 + CreditWidth;

endpackage

`default_nettype wire

/* hdl/bridge_types_pkg.sv */
// Channel encoding and packet layout shared by both sides of the AXIS link
// Field order of axis_packet_t matches {tdata, tuser} from the top bit down
`default_nettype none

package bridge_types_pkg;

  // Virtual channel, used as data header and credit header
  typedef enum logic {
    VC_REQ = 1'b0,
    VC_RSP = 1'b1
  } vc_e;

  typedef logic [bridge_cfg_pkg::FlitWidth-1:0] flit_data_t;

  typedef logic [bridge_cfg_pkg::CreditWidth-1:0] credit_t;

  //////////////////////////////
  // Packet on the AXIS link
  //////////////////////////////

  // tdata = {data_vc, data}
  // tuser = {data_valid, credit_vc, credits}
  typedef struct packed {
    vc_e        data_vc;
    flit_data_t data;
    logic       data_valid;
    vc_e        credit_vc;
    credit_t    credits;
  } axis_packet_t;

endpackage

`default_nettype wire

/* hdl/vc_tx_if.sv */
// Request path from one channel's credit synchronizer to the AXIS packer
// One instance per virtual channel
`timescale 1ns/10ps
`default_nettype none

interface vc_tx_if;

  logic                         valid;
  logic                         ready;
  bridge_types_pkg::flit_data_t data;
  // No payload, only a credit return
  logic                         cred_only;
  // Credits owed to the far end, valid every cycle
  bridge_types_pkg::credit_t    owed;

  modport sync (
    output valid, data, cred_only, owed,
    input  ready
  );

  modport packer (
    input  valid, data, cred_only, owed,
    output ready
  );

endinterface

`default_nettype wire

/* hdl/credit_sync.sv */
// Per-channel credit keeper on the transmit side
// Gates flits on the send counter and tracks credits owed to the far end
`timescale 1ns/10ps
`default_nettype none

module credit_sync (
  input  logic                         clk_i,
  input  logic                         arst_n_i,

  // Flits from the NoC input
  input  logic                         flit_valid_i,
  input  bridge_types_pkg::flit_data_t flit_data_i,
  output logic                         flit_ready_o,

  // Towards the packer
  vc_tx_if.sync                        tx,

  // Packet with this channel's credits entered the output stage
  input  logic                         taken_i,
  // Receive queue handed a flit to the NoC
  input  logic                         drain_i,

  // Credits returned by the far end for this channel
  input  logic                         rx_cred_valid_i,
  input  bridge_types_pkg::credit_t    rx_credits_i
);

  bridge_types_pkg::credit_t send_cnt_q;
  bridge_types_pkg::credit_t send_cnt_d;
  bridge_types_pkg::credit_t owed_q;
  bridge_types_pkg::credit_t owed_d;

  logic has_credit;
  logic data_ok;
  logic cred_only;
  logic flit_xfer;

  //////////////////////////////
  // Request towards the packer
  //////////////////////////////

  assign has_credit = (send_cnt_q != '0);

  // A flit may only leave while the far end has room for it
  assign data_ok = flit_valid_i & has_credit;

  // Credit-only request when enough is owed and no data can carry it
  assign cred_only = (owed_q >= bridge_types_pkg::credit_t'(bridge_cfg_pkg::ForceSendThresh))
                     & ~data_ok;

  assign tx.valid     = data_ok | cred_only;
  assign tx.data      = flit_data_i;
  assign tx.cred_only = cred_only;
  assign tx.owed      = owed_q;

  assign flit_ready_o = tx.ready & data_ok;
  assign flit_xfer    = flit_valid_i & flit_ready_o;

  //////////////////////////////
  // Credit counters
  //////////////////////////////

  always_comb begin
    send_cnt_d = send_cnt_q;
    if (flit_xfer) begin
      send_cnt_d = send_cnt_d - bridge_types_pkg::credit_t'(1);
    end
    if (rx_cred_valid_i) begin
      send_cnt_d = send_cnt_d + rx_credits_i;
    end
  end

  // Reported credits equal owed_q, so taking clears the count
  // while a drain in the same cycle is still counted
  always_comb begin
    owed_d = taken_i ? '0 : owed_q;
    if (drain_i) begin
      owed_d = owed_d + bridge_types_pkg::credit_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      send_cnt_q <= bridge_types_pkg::credit_t'(bridge_cfg_pkg::NumCredits);
      owed_q     <= '0;
    end else begin
      send_cnt_q <= send_cnt_d;
      owed_q     <= owed_d;
    end
  end

endmodule

`default_nettype wire

/* hdl/axis_packer.sv */
// Round-robin merge of the two channel requests into one packet stream
// Each packet piggy-backs the credits of the channel owed more
`timescale 1ns/10ps
`default_nettype none

module axis_packer (
  input  logic                           clk_i,
  input  logic                           arst_n_i,

  vc_tx_if.packer                        req_tx,
  vc_tx_if.packer                        rsp_tx,

  // Credits of that channel left with the packet
  output logic                           taken_req_o,
  output logic                           taken_rsp_o,

  output logic                           pkt_valid_o,
  output bridge_types_pkg::axis_packet_t pkt_o,
  input  logic                           pkt_ready_i
);

  bridge_types_pkg::axis_packet_t req_pkt;
  bridge_types_pkg::axis_packet_t rsp_pkt;
  bridge_types_pkg::vc_e          cred_vc;
  bridge_types_pkg::credit_t      cred_cnt;
  bridge_types_pkg::vc_e          grant;
  bridge_types_pkg::vc_e          rr_q;
  bridge_types_pkg::vc_e          lock_vc_q;
  logic                           lock_q;
  logic                           xfer;

  //////////////////////////////
  // Candidate packets
  //////////////////////////////

  // Strictly more owed wins, a tie goes to the response channel
  assign cred_vc  = (req_tx.owed > rsp_tx.owed) ? bridge_types_pkg::VC_REQ
                                                : bridge_types_pkg::VC_RSP;
  assign cred_cnt = (req_tx.owed > rsp_tx.owed) ? req_tx.owed : rsp_tx.owed;

  always_comb begin
    req_pkt.data_vc    = bridge_types_pkg::VC_REQ;
    req_pkt.data       = req_tx.data;
    req_pkt.data_valid = ~req_tx.cred_only;
    req_pkt.credit_vc  = cred_vc;
    req_pkt.credits    = cred_cnt;

    rsp_pkt.data_vc    = bridge_types_pkg::VC_RSP;
    rsp_pkt.data       = rsp_tx.data;
    rsp_pkt.data_valid = ~rsp_tx.cred_only;
    rsp_pkt.credit_vc  = cred_vc;
    rsp_pkt.credits    = cred_cnt;
  end

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  always_comb begin
    if (lock_q) begin
      grant = lock_vc_q;
    end else if (req_tx.valid && rsp_tx.valid) begin
      grant = rr_q;
    end else if (req_tx.valid) begin
      grant = bridge_types_pkg::VC_REQ;
    end else begin
      grant = bridge_types_pkg::VC_RSP;
    end
  end

  assign pkt_valid_o = (grant == bridge_types_pkg::VC_REQ) ? req_tx.valid : rsp_tx.valid;
  assign pkt_o       = (grant == bridge_types_pkg::VC_REQ) ? req_pkt : rsp_pkt;
  assign xfer        = pkt_valid_o & pkt_ready_i;

  assign req_tx.ready = pkt_ready_i & (grant == bridge_types_pkg::VC_REQ);
  assign rsp_tx.ready = pkt_ready_i & (grant == bridge_types_pkg::VC_RSP);

  assign taken_req_o = xfer & (pkt_o.credit_vc == bridge_types_pkg::VC_REQ);
  assign taken_rsp_o = xfer & (pkt_o.credit_vc == bridge_types_pkg::VC_RSP);

  // Hold a stalled grant, pointer moves past the winner on transfer
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rr_q      <= bridge_types_pkg::VC_REQ;
      lock_vc_q <= bridge_types_pkg::VC_REQ;
      lock_q    <= 1'b0;
    end else begin
      lock_q    <= pkt_valid_o & ~pkt_ready_i;
      lock_vc_q <= grant;
      if (xfer) begin
        rr_q <= (grant == bridge_types_pkg::VC_REQ) ? bridge_types_pkg::VC_RSP
                                                    : bridge_types_pkg::VC_REQ;
      end
    end
  end

endmodule

`default_nettype wire

/* hdl/axis_unpacker.sv */
// Receive-side decode of AXIS beats into channel writes and credit returns
// Purely combinational, sits between the AXIS input and the receive queues
`timescale 1ns/10ps
`default_nettype none

module axis_unpacker (
  input  logic                                  tvalid_i,
  input  logic [bridge_cfg_pkg::TdataWidth-1:0] tdata_i,
  input  logic [bridge_cfg_pkg::TuserWidth-1:0] tuser_i,
  output logic                                  tready_o,

  // Writes into the receive queues
  output logic                                  req_wvalid_o,
  output logic                                  rsp_wvalid_o,
  output bridge_types_pkg::flit_data_t          wdata_o,
  input  logic                                  req_wready_i,
  input  logic                                  rsp_wready_i,

  // Credits returned by the far end
  output logic                                  rx_cred_valid_o,
  output bridge_types_pkg::vc_e                 rx_cred_vc_o,
  output bridge_types_pkg::credit_t             rx_credits_o
);

  bridge_types_pkg::axis_packet_t pkt;
  logic                           is_req;

  // Struct layout matches {tdata, tuser}
  assign pkt    = bridge_types_pkg::axis_packet_t'({tdata_i, tuser_i});
  assign is_req = (pkt.data_vc == bridge_types_pkg::VC_REQ);

  assign req_wvalid_o = tvalid_i & pkt.data_valid & is_req;
  assign rsp_wvalid_o = tvalid_i & pkt.data_valid & ~is_req;
  assign wdata_o      = pkt.data;

  // Credit-only beats never wait on a queue
  assign tready_o = ~pkt.data_valid | (is_req ? req_wready_i : rsp_wready_i);

  assign rx_cred_valid_o = tvalid_i & tready_o;
  assign rx_cred_vc_o    = pkt.credit_vc;
  assign rx_credits_o    = pkt.credits;

endmodule

`default_nettype wire

/* hdl/vc_fifo.sv */
// Valid/ready FIFO with a fill count, any depth and payload type
// Output comes straight from storage, so it holds under back-pressure
`timescale 1ns/10ps
`default_nettype none

module vc_fifo #(
  parameter int  Depth = 2,
  parameter type T     = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,

  input  logic valid_i,
  input  T     data_i,
  output logic ready_o,

  output logic valid_o,
  output T     data_o,
  input  logic ready_i
);

  localparam int AddrWidth  = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int CountWidth = $clog2(Depth + 1);

  T                      mem [Depth];
  logic [AddrWidth-1:0]  wr_ptr_q;
  logic [AddrWidth-1:0]  rd_ptr_q;
  logic [CountWidth-1:0] count_q;
  logic                  push;
  logic                  pop;

  assign ready_o = (count_q != CountWidth'(Depth));
  assign valid_o = (count_q != '0);
  assign data_o  = mem[rd_ptr_q];

  assign push = valid_i & ready_o;
  assign pop  = valid_o & ready_i;

  always_ff @(posedge clk_i) begin
    if (push) begin
      mem[wr_ptr_q] <= data_i;
    end
  end

  // Pointers wrap at Depth, which need not be a power of two
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == AddrWidth'(Depth - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == AddrWidth'(Depth - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/noc_axis_bridge.sv */
// Top level of the credit-based bridge between a two-channel NoC port and AXIS
// Transmit path merges both channels, receive path splits them into queues
`timescale 1ns/10ps
`default_nettype none

module noc_axis_bridge (
  input  logic                                  clk_i,
  input  logic                                  arst_n_i,

  // NoC inputs
  input  logic                                  req_in_valid_i,
  input  bridge_types_pkg::flit_data_t          req_in_data_i,
  output logic                                  req_in_ready_o,
  input  logic                                  rsp_in_valid_i,
  input  bridge_types_pkg::flit_data_t          rsp_in_data_i,
  output logic                                  rsp_in_ready_o,

  // NoC outputs
  output logic                                  req_out_valid_o,
  output bridge_types_pkg::flit_data_t          req_out_data_o,
  input  logic                                  req_out_ready_i,
  output logic                                  rsp_out_valid_o,
  output bridge_types_pkg::flit_data_t          rsp_out_data_o,
  input  logic                                  rsp_out_ready_i,

  // AXIS towards the far end
  output logic                                  axis_out_tvalid_o,
  output logic [bridge_cfg_pkg::TdataWidth-1:0] axis_out_tdata_o,
  output logic [bridge_cfg_pkg::TuserWidth-1:0] axis_out_tuser_o,
  input  logic                                  axis_out_tready_i,

  // AXIS from the far end
  input  logic                                  axis_in_tvalid_i,
  input  logic [bridge_cfg_pkg::TdataWidth-1:0] axis_in_tdata_i,
  input  logic [bridge_cfg_pkg::TuserWidth-1:0] axis_in_tuser_i,
  output logic                                  axis_in_tready_o
);

  vc_tx_if req_tx_if ();
  vc_tx_if rsp_tx_if ();

  logic                           taken_req;
  logic                           taken_rsp;
  logic                           pkt_valid;
  logic                           pkt_ready;
  bridge_types_pkg::axis_packet_t pkt;
  bridge_types_pkg::axis_packet_t out_pkt;

  logic                           req_wvalid;
  logic                           rsp_wvalid;
  logic                           req_wready;
  logic                           rsp_wready;
  bridge_types_pkg::flit_data_t   wdata;
  logic                           rx_cred_valid;
  bridge_types_pkg::vc_e          rx_cred_vc;
  bridge_types_pkg::credit_t      rx_credits;
  logic                           req_rx_cred;
  logic                           rsp_rx_cred;
  logic                           req_drain;
  logic                           rsp_drain;

  //////////////////////////////
  // Transmit path
  //////////////////////////////

  assign req_rx_cred = rx_cred_valid & (rx_cred_vc == bridge_types_pkg::VC_REQ);
  assign rsp_rx_cred = rx_cred_valid & (rx_cred_vc == bridge_types_pkg::VC_RSP);
  assign req_drain   = req_out_valid_o & req_out_ready_i;
  assign rsp_drain   = rsp_out_valid_o & rsp_out_ready_i;

  credit_sync u_req_sync (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .flit_valid_i    (req_in_valid_i),
    .flit_data_i     (req_in_data_i),
    .flit_ready_o    (req_in_ready_o),
    .tx              (req_tx_if.sync),
    .taken_i         (taken_req),
    .drain_i         (req_drain),
    .rx_cred_valid_i (req_rx_cred),
    .rx_credits_i    (rx_credits)
  );

  credit_sync u_rsp_sync (
    .clk_i           (clk_i),
    .arst_n_i        (arst_n_i),
    .flit_valid_i    (rsp_in_valid_i),
    .flit_data_i     (rsp_in_data_i),
    .flit_ready_o    (rsp_in_ready_o),
    .tx              (rsp_tx_if.sync),
    .taken_i         (taken_rsp),
    .drain_i         (rsp_drain),
    .rx_cred_valid_i (rsp_rx_cred),
    .rx_credits_i    (rx_credits)
  );

  axis_packer u_packer (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .req_tx      (req_tx_if.packer),
    .rsp_tx      (rsp_tx_if.packer),
    .taken_req_o (taken_req),
    .taken_rsp_o (taken_rsp),
    .pkt_valid_o (pkt_valid),
    .pkt_o       (pkt),
    .pkt_ready_i (pkt_ready)
  );

  // Registered stage keeps tdata and tuser stable while stalled
  vc_fifo #(
    .Depth (bridge_cfg_pkg::OutDepth),
    .T     (bridge_types_pkg::axis_packet_t)
  ) u_out_stage (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (pkt_valid),
    .data_i   (pkt),
    .ready_o  (pkt_ready),
    .valid_o  (axis_out_tvalid_o),
    .data_o   (out_pkt),
    .ready_i  (axis_out_tready_i)
  );

  assign axis_out_tdata_o = {out_pkt.data_vc, out_pkt.data};
  assign axis_out_tuser_o = {out_pkt.data_valid, out_pkt.credit_vc, out_pkt.credits};

  //////////////////////////////
  // Receive path
  //////////////////////////////

  axis_unpacker u_unpacker (
    .tvalid_i        (axis_in_tvalid_i),
    .tdata_i         (axis_in_tdata_i),
    .tuser_i         (axis_in_tuser_i),
    .tready_o        (axis_in_tready_o),
    .req_wvalid_o    (req_wvalid),
    .rsp_wvalid_o    (rsp_wvalid),
    .wdata_o         (wdata),
    .req_wready_i    (req_wready),
    .rsp_wready_i    (rsp_wready),
    .rx_cred_valid_o (rx_cred_valid),
    .rx_cred_vc_o    (rx_cred_vc),
    .rx_credits_o    (rx_credits)
  );

  vc_fifo #(
    .Depth (bridge_cfg_pkg::NumCredits),
    .T     (bridge_types_pkg::flit_data_t)
  ) u_req_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (req_wvalid),
    .data_i   (wdata),
    .ready_o  (req_wready),
    .valid_o  (req_out_valid_o),
    .data_o   (req_out_data_o),
    .ready_i  (req_out_ready_i)
  );

  vc_fifo #(
    .Depth (bridge_cfg_pkg::NumCredits),
    .T     (bridge_types_pkg::flit_data_t)
  ) u_rsp_queue (
    .clk_i    (clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (rsp_wvalid),
    .data_i   (wdata),
    .ready_o  (rsp_wready),
    .valid_o  (rsp_out_valid_o),
    .data_o   (rsp_out_data_o),
    .ready_i  (rsp_out_ready_i)
  );

endmodule

`default_nettype wire

/* tests/noc_axis_bridge_props.sv */
// Bound checks on the bridge: AXIS output stability and transmit credit bounds
// Attached to every noc_axis_bridge instance through the bind below
`timescale 1ns/10ps
`default_nettype none

module noc_axis_bridge_props (
  input logic                                  clk_i,
  input logic                                  arst_n_i,
  input logic                                  tvalid_i,
  input logic                                  tready_i,
  input logic [bridge_cfg_pkg::TdataWidth-1:0] tdata_i,
  input logic [bridge_cfg_pkg::TuserWidth-1:0] tuser_i,
  input bridge_types_pkg::credit_t             req_send_cnt_i,
  input bridge_types_pkg::credit_t             rsp_send_cnt_i,
  input logic                                  pkt_valid_i,
  input logic                                  pkt_ready_i,
  input bridge_types_pkg::axis_packet_t        pkt_i
);

  // Stalled beat holds its payload
  stable_out_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    tvalid_i && !tready_i |=> $stable(tdata_i) && $stable(tuser_i))
    else $error("AXIS payload changed while stalled");

  req_cnt_bound_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req_send_cnt_i <= bridge_types_pkg::credit_t'(bridge_cfg_pkg::NumCredits))
    else $error("request send counter above credit limit");

  rsp_cnt_bound_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rsp_send_cnt_i <= bridge_types_pkg::credit_t'(bridge_cfg_pkg::NumCredits))
    else $error("response send counter above credit limit");

  // No data packet may enter the output stage without a credit
  req_no_credit_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pkt_valid_i && pkt_ready_i && pkt_i.data_valid &&
    pkt_i.data_vc == bridge_types_pkg::VC_REQ |-> req_send_cnt_i != '0)
    else $error("request flit granted at zero credits");

  rsp_no_credit_a : assert property (@(posedge clk_i) disable iff (!arst_n_i)
    pkt_valid_i && pkt_ready_i && pkt_i.data_valid &&
    pkt_i.data_vc == bridge_types_pkg::VC_RSP |-> rsp_send_cnt_i != '0)
    else $error("response flit granted at zero credits");

endmodule

bind noc_axis_bridge noc_axis_bridge_props u_props (
  .clk_i          (clk_i),
  .arst_n_i       (arst_n_i),
  .tvalid_i       (axis_out_tvalid_o),
  .tready_i       (axis_out_tready_i),
  .tdata_i        (axis_out_tdata_o),
  .tuser_i        (axis_out_tuser_o),
  .req_send_cnt_i (u_req_sync.send_cnt_q),
  .rsp_send_cnt_i (u_rsp_sync.send_cnt_q),
  .pkt_valid_i    (pkt_valid),
  .pkt_ready_i    (pkt_ready),
  .pkt_i          (pkt)
);

`default_nettype wire

/* tests/noc_axis_bridge_tb.sv */
// Testbench for the NoC to AXIS bridge with a far-end model and scoreboards
// Runs reset, credit-limited transmit, credit return and receive phases
`timescale 1ns/10ps
`default_nettype none

module noc_axis_bridge_tb;

  localparam int ClkPeriod      = 8;
  localparam int TxFlits        = 12;
  localparam int RxFlits        = 20;
  localparam int PlannedXfers   = 2 * TxFlits + 2 * RxFlits + 2;
  localparam int WatchdogCycles = PlannedXfers * 40 + 2000;

  logic                                  clk;
  logic                                  arst_n;
  logic                                  req_in_valid;
  bridge_types_pkg::flit_data_t          req_in_data;
  logic                                  req_in_ready;
  logic                                  rsp_in_valid;
  bridge_types_pkg::flit_data_t          rsp_in_data;
  logic                                  rsp_in_ready;
  logic                                  req_out_valid;
  bridge_types_pkg::flit_data_t          req_out_data;
  logic                                  req_out_ready;
  logic                                  rsp_out_valid;
  bridge_types_pkg::flit_data_t          rsp_out_data;
  logic                                  rsp_out_ready;
  logic                                  axis_out_tvalid;
  logic [bridge_cfg_pkg::TdataWidth-1:0] axis_out_tdata;
  logic [bridge_cfg_pkg::TuserWidth-1:0] axis_out_tuser;
  logic                                  axis_out_tready;
  logic                                  axis_in_tvalid;
  logic [bridge_cfg_pkg::TdataWidth-1:0] axis_in_tdata;
  logic [bridge_cfg_pkg::TuserWidth-1:0] axis_in_tuser;
  logic                                  axis_in_tready;

  // Scoreboards and far-end state, index 0 is request, 1 is response
  bridge_types_pkg::flit_data_t exp_tx [2][$];
  bridge_types_pkg::flit_data_t exp_rx [2][$];
  int tx_left [2];
  int rx_left [2];
  int cred_ret [2];
  int fe_cred [2];
  int tx_out_cnt [2];
  int rx_out_cnt [2];
  int drained [2];
  int returned [2];
  int value_errs;
  int other_errs;

  noc_axis_bridge UUT (
    .clk_i (clk), .arst_n_i (arst_n),
    .req_in_valid_i (req_in_valid), .req_in_data_i (req_in_data),
    .req_in_ready_o (req_in_ready),
    .rsp_in_valid_i (rsp_in_valid), .rsp_in_data_i (rsp_in_data),
    .rsp_in_ready_o (rsp_in_ready),
    .req_out_valid_o (req_out_valid), .req_out_data_o (req_out_data),
    .req_out_ready_i (req_out_ready),
    .rsp_out_valid_o (rsp_out_valid), .rsp_out_data_o (rsp_out_data),
    .rsp_out_ready_i (rsp_out_ready),
    .axis_out_tvalid_o (axis_out_tvalid), .axis_out_tdata_o (axis_out_tdata),
    .axis_out_tuser_o (axis_out_tuser), .axis_out_tready_i (axis_out_tready),
    .axis_in_tvalid_i (axis_in_tvalid), .axis_in_tdata_i (axis_in_tdata),
    .axis_in_tuser_i (axis_in_tuser), .axis_in_tready_o (axis_in_tready)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  //////////////////////////////
  // Reference model
  //////////////////////////////

  // Data packets that may leave one channel for the credits granted
  function automatic int expected_leaving(input int offered, input int credits);
    return (offered < credits) ? offered : credits;
  endfunction

  // Channel whose oldest outstanding flit carries this data
  function automatic int data_channel(input bridge_types_pkg::flit_data_t d, input int hdr);
    if (exp_tx[0].size() != 0 && exp_tx[0][0] == d) return 0;
    if (exp_tx[1].size() != 0 && exp_tx[1][0] == d) return 1;
    return hdr;
  endfunction

  // Data part of the packet a flit must produce on axis_out
  function automatic bridge_types_pkg::axis_packet_t expected_packet(
      input int vc, input bridge_types_pkg::flit_data_t d);
    bridge_types_pkg::axis_packet_t p;
    p            = '0;
    p.data_vc    = bridge_types_pkg::vc_e'(vc);
    p.data       = d;
    p.data_valid = 1'b1;
    return p;
  endfunction

  //////////////////////////////
  // Compare tasks
  //////////////////////////////

  // Credit fields are checked separately against the drain counts
  task automatic check_packet(input string name, input bridge_types_pkg::axis_packet_t got,
                              input bridge_types_pkg::axis_packet_t exp);
    if (got.data_vc !== exp.data_vc || got.data !== exp.data ||
        got.data_valid !== exp.data_valid) begin
      value_errs++;
      $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_flit(input string name, input bridge_types_pkg::flit_data_t got,
                            input bridge_types_pkg::flit_data_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  task automatic check_credit(input string name, input bridge_types_pkg::credit_t got,
                              input bridge_types_pkg::credit_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("mismatch %s got 0x%h expected 0x%h", name, got, exp);
    end
  endtask

  //////////////////////////////
  // NoC side stimulus
  //////////////////////////////

  always @(posedge clk) begin
    if (arst_n) begin
      if (!req_in_valid || req_in_ready) begin
        req_in_valid <= 1'b0;
        if (tx_left[0] > 0 && $urandom_range(3) != 0) begin
          req_in_valid <= 1'b1;
          req_in_data  <= $urandom();
          tx_left[0]   = tx_left[0] - 1;
        end
      end
      if (!rsp_in_valid || rsp_in_ready) begin
        rsp_in_valid <= 1'b0;
        if (tx_left[1] > 0 && $urandom_range(3) != 0) begin
          rsp_in_valid <= 1'b1;
          rsp_in_data  <= $urandom();
          tx_left[1]   = tx_left[1] - 1;
        end
      end
      req_out_ready   <= $urandom_range(1);
      rsp_out_ready   <= $urandom_range(1);
      axis_out_tready <= ($urandom_range(3) != 0);
    end
  end

  //////////////////////////////
  // Far end and compare
  //////////////////////////////

  always @(posedge clk) begin
    bridge_types_pkg::axis_packet_t pkt;
    bridge_types_pkg::axis_packet_t beat;
    int vc;
    if (arst_n) begin
      if (req_in_valid && req_in_ready) exp_tx[0].push_back(req_in_data);
      if (rsp_in_valid && rsp_in_ready) exp_tx[1].push_back(rsp_in_data);

      if (axis_out_tvalid && axis_out_tready) begin
        pkt = bridge_types_pkg::axis_packet_t'({axis_out_tdata, axis_out_tuser});
        vc  = int'(pkt.credit_vc);
        if (int'(pkt.credits) > drained[vc] - returned[vc]) begin
          other_errs++;
          $display("credit return on channel %0d exceeds flits drained", vc);
        end
        // A request return needs strictly more owed, never zero
        if (pkt.credit_vc == bridge_types_pkg::VC_REQ && pkt.credits == '0) begin
          other_errs++;
          $display("empty credit return named the request channel instead of response");
        end
        if (!pkt.data_valid && int'(pkt.credits) < bridge_cfg_pkg::ForceSendThresh) begin
          other_errs++;
          $display("credit-only packet carries fewer credits than the threshold");
        end
        returned[vc] += int'(pkt.credits);
        fe_cred[vc]  += int'(pkt.credits);
        if (pkt.data_valid) begin
          vc = data_channel(pkt.data, int'(pkt.data_vc));
          if (exp_tx[vc].size() == 0) begin
            other_errs++;
            $display("data packet on axis_out with no flit sent on channel %0d", vc);
          end else begin
            check_packet("axis_out packet", pkt, expected_packet(vc, exp_tx[vc].pop_front()));
          end
          tx_out_cnt[vc]++;
        end
      end

      if (req_out_valid && req_out_ready) begin
        if (exp_rx[0].size() == 0) begin
          other_errs++;
          $display("flit on req_out that the far end never sent");
        end else begin
          check_flit("req_out_data", req_out_data, exp_rx[0].pop_front());
        end
        drained[0]++;
        rx_out_cnt[0]++;
      end
      if (rsp_out_valid && rsp_out_ready) begin
        if (exp_rx[1].size() == 0) begin
          other_errs++;
          $display("flit on rsp_out that the far end never sent");
        end else begin
          check_flit("rsp_out_data", rsp_out_data, exp_rx[1].pop_front());
        end
        drained[1]++;
        rx_out_cnt[1]++;
      end

      if (axis_in_tvalid && axis_in_tready) begin
        beat = bridge_types_pkg::axis_packet_t'({axis_in_tdata, axis_in_tuser});
        if (beat.data_valid) exp_rx[int'(beat.data_vc)].push_back(beat.data);
      end

      // Next beat: credit returns first, data only within far-end credit
      if (!axis_in_tvalid || axis_in_tready) begin
        axis_in_tvalid <= 1'b0;
        beat = '0;
        vc   = $urandom_range(1);
        if (cred_ret[0] > 0 || cred_ret[1] > 0) begin
          vc             = (cred_ret[0] > 0) ? 0 : 1;
          beat.credit_vc = bridge_types_pkg::vc_e'(vc);
          beat.credits   = bridge_types_pkg::credit_t'(cred_ret[vc]);
          cred_ret[vc]   = 0;
          axis_in_tvalid <= 1'b1;
        end else if (rx_left[vc] > 0 && fe_cred[vc] > 0 && $urandom_range(2) != 0) begin
          beat.data_vc    = bridge_types_pkg::vc_e'(vc);
          beat.data       = $urandom();
          beat.data_valid = 1'b1;
          rx_left[vc]--;
          fe_cred[vc]--;
          axis_in_tvalid <= 1'b1;
        end
        axis_in_tdata <= {beat.data_vc, beat.data};
        axis_in_tuser <= {beat.data_valid, beat.credit_vc, beat.credits};
      end
    end
  end

  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Timeout: traffic did not complete within %0d cycles", WatchdogCycles);
    $display("Some tests failed");
    $finish;
  end

  //////////////////////////////
  // Test sequence
  //////////////////////////////

  initial begin
    void'($urandom(94953));
    arst_n = 1'b0;
    {req_in_valid, req_in_data, rsp_in_valid, rsp_in_data} = '0;
    {req_out_ready, rsp_out_ready, axis_out_tready} = '0;
    {axis_in_tvalid, axis_in_tdata, axis_in_tuser} = '0;
    value_errs = 0;
    other_errs = 0;
    for (int i = 0; i < 2; i++) begin
      tx_left[i] = 0;
      rx_left[i] = 0;
      cred_ret[i] = 0;
      fe_cred[i] = bridge_cfg_pkg::NumCredits;
      tx_out_cnt[i] = 0;
      rx_out_cnt[i] = 0;
      drained[i] = 0;
      returned[i] = 0;
    end
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    // Idle bridge must stay quiet
    repeat (20) begin
      @(negedge clk);
      if (axis_out_tvalid || req_out_valid || rsp_out_valid) begin
        other_errs++;
        $display("output valid raised after reset without traffic");
      end
    end

    // Transmit without any credit return from the far end
    @(negedge clk);
    tx_left[0] = TxFlits;
    tx_left[1] = TxFlits;
    wait (tx_out_cnt[0] >= bridge_cfg_pkg::NumCredits &&
          tx_out_cnt[1] >= bridge_cfg_pkg::NumCredits);
    repeat (40) @(negedge clk);
    check_credit("req packets before return", bridge_types_pkg::credit_t'(tx_out_cnt[0]),
      bridge_types_pkg::credit_t'(expected_leaving(TxFlits, bridge_cfg_pkg::NumCredits)));
    check_credit("rsp packets before return", bridge_types_pkg::credit_t'(tx_out_cnt[1]),
      bridge_types_pkg::credit_t'(expected_leaving(TxFlits, bridge_cfg_pkg::NumCredits)));

    // Credit-only beats from the far end release the rest
    @(negedge clk);
    cred_ret[0] = bridge_cfg_pkg::NumCredits;
    cred_ret[1] = bridge_cfg_pkg::NumCredits;
    wait (tx_out_cnt[0] >= TxFlits && tx_out_cnt[1] >= TxFlits);
    repeat (40) @(negedge clk);
    check_credit("req packets after return", bridge_types_pkg::credit_t'(tx_out_cnt[0]),
      bridge_types_pkg::credit_t'(expected_leaving(TxFlits, 2 * bridge_cfg_pkg::NumCredits)));
    check_credit("rsp packets after return", bridge_types_pkg::credit_t'(tx_out_cnt[1]),
      bridge_types_pkg::credit_t'(expected_leaving(TxFlits, 2 * bridge_cfg_pkg::NumCredits)));

    // Receive path, far end paced by returned credits
    @(negedge clk);
    rx_left[0] = RxFlits;
    rx_left[1] = RxFlits;
    wait (rx_out_cnt[0] >= RxFlits && rx_out_cnt[1] >= RxFlits);
    repeat (60) @(negedge clk);

    for (int i = 0; i < 2; i++) begin
      if (drained[i] - returned[i] > bridge_cfg_pkg::ForceSendThresh - 1) begin
        other_errs++;
        $display("channel %0d still owes %0d credits after idle", i, drained[i] - returned[i]);
      end
      if (exp_tx[i].size() != 0 || exp_rx[i].size() != 0) begin
        other_errs++;
        $display("channel %0d has flits that never arrived", i);
      end
    end

    $display("Error counts: value %0d, other %0d", value_errs, other_errs);
    if (value_errs == 0 && other_errs == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
hdl/bridge_cfg_pkg.sv
hdl/bridge_types_pkg.sv
hdl/vc_tx_if.sv
hdl/credit_sync.sv
hdl/axis_packer.sv
hdl/axis_unpacker.sv
hdl/vc_fifo.sv
hdl/noc_axis_bridge.sv
tests/noc_axis_bridge_props.sv
tests/noc_axis_bridge_tb.sv
